//--- rtl/spi_target_consts.svh
`ifndef SPI_TARGET_CONSTS_SVH
`define SPI_TARGET_CONSTS_SVH

// Register file geometry
// Register 0 is the read-only ID, the rest are read/write
`define SPI_REG_COUNT 8

// Contents of register 0
`define SPI_REG_ID_VALUE 32'h5350_0001

// Command opcodes, carried in the first byte on the wire
`define SPI_OP_WRITE 8'h01
`define SPI_OP_READ 8'h02

// Flops per input synchronizer
// Edge detection uses the last two stages
`define SPI_SYNC_STAGES 3

`endif

//--- rtl/spi_target_pkg.sv
`default_nettype none

package spi_target_pkg;

  // One 64-bit command frame
  // Byte 0 on the wire lands in bits 7:0, so op goes out first
  typedef struct packed {
    // Write data or read reply data
    logic [31:0] data;
    // Unused, zero in replies
    logic [15:0] rsvd;
    // Register address
    logic [7:0] addr;
    // Opcode
    logic [7:0] op;
  } spi_cmd_t;

  // Same word seen two ways
  // Framer handles raw bytes, register file decodes cmd
  typedef union packed {
    logic [63:0] raw;
    spi_cmd_t cmd;
  } spi_frame_u;

endpackage

`default_nettype wire

//--- rtl/spi_byte_if.sv
`default_nettype none

// Byte-level link between the SPI byte engine and the word framer
interface spi_byte_if;

  // Last received byte, valid while rx_strobe is high
  logic [7:0] rx_byte;
  // One clk pulse per completed byte
  logic rx_strobe;
  // Synchronized CS, active high
  logic frame_active;
  // Byte to shift out on CIPO
  // Held from last rising SCK of a byte to first falling SCK of the next
  logic [7:0] tx_byte;

  modport engine (
    output rx_byte, rx_strobe, frame_active,
    input tx_byte
  );

  modport framer (
    input rx_byte, rx_strobe, frame_active,
    output tx_byte
  );

endinterface

`default_nettype wire

//--- rtl/spi_byte_engine.sv
`default_nettype none

`include "spi_target_consts.svh"

// Mode 0 SPI target, one byte at a time
// Pins are sampled in the clk domain, clk must be at least 4x SCK
module spi_byte_engine (
  input wire clk,
  input wire arst_n,
  input wire sck,
  input wire cs_n,
  input wire copi,
  output logic cipo,
  output logic cipo_en,
  spi_byte_if.engine byte_bus
);

  // Synchronizer chains, bit 0 is the newest sample
  logic [`SPI_SYNC_STAGES-1:0] sck_sync;
  logic [`SPI_SYNC_STAGES-1:0] cs_sync;
  logic [`SPI_SYNC_STAGES-1:0] copi_sync;

  // SCK edge events, one clk wide
  logic sck_rise;
  logic sck_fall;
  // COPI as seen at the oldest stage
  logic copi_bit;

  // Receive count goes up on rising SCK
  logic [2:0] rx_cnt;
  // Transmit index goes down on falling SCK
  logic [2:0] tx_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_sync <= '0;
      // CS idles high
      cs_sync <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync <= {sck_sync[`SPI_SYNC_STAGES-2:0], sck};
      cs_sync <= {cs_sync[`SPI_SYNC_STAGES-2:0], cs_n};
      copi_sync <= {copi_sync[`SPI_SYNC_STAGES-2:0], copi};
    end
  end

  // Compare the two oldest SCK samples
  assign sck_rise = ({sck_sync[`SPI_SYNC_STAGES-1], sck_sync[`SPI_SYNC_STAGES-2]} == 2'b01);
  assign sck_fall = ({sck_sync[`SPI_SYNC_STAGES-1], sck_sync[`SPI_SYNC_STAGES-2]} == 2'b10);

  // CS is active low on the pin
  assign byte_bus.frame_active = ~cs_sync[`SPI_SYNC_STAGES-1];
  // COPI lags SCK by a stage, still well inside the half period
  assign copi_bit = copi_sync[`SPI_SYNC_STAGES-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt <= 3'd0;
      tx_cnt <= 3'd7;
      byte_bus.rx_strobe <= 1'b0;
      cipo_en <= 1'b0;
    end else begin
      // Registered so the pin enable does not glitch
      cipo_en <= byte_bus.frame_active;
      byte_bus.rx_strobe <= 1'b0;
      if (byte_bus.frame_active) begin
        if (sck_rise) begin
          rx_cnt <= rx_cnt + 3'd1;
          // Eighth bit done, pulse for one clk
          byte_bus.rx_strobe <= (rx_cnt == 3'd7);
        end
        if (sck_fall) begin
          // Wraps to 7 at the end of each byte
          tx_cnt <= tx_cnt - 3'd1;
        end
      end else begin
        // Idle or aborted transfer, start clean next time
        rx_cnt <= 3'd0;
        tx_cnt <= 3'd7;
      end
    end
  end

  // Receive shifter, MSB first
  always_ff @(posedge clk) begin
    if (byte_bus.frame_active && sck_rise) begin
      byte_bus.rx_byte <= {byte_bus.rx_byte[6:0], copi_bit};
    end
  end

  // Not gated by CS, so the MSB is already on the line before the first edge
  assign cipo = byte_bus.tx_byte[tx_cnt];

  // Byte strobes are at least eight SCK edges apart
  rx_strobe_single: assert property (
    @(posedge clk) disable iff (!arst_n)
    byte_bus.rx_strobe |=> !byte_bus.rx_strobe
  );

  // Enable must be up before any SCK edge is used
  // Needs at least one clk of CS setup
  cipo_en_before_edge: assert property (
    @(posedge clk) disable iff (!arst_n)
    (byte_bus.frame_active && (sck_rise || sck_fall)) |-> cipo_en
  );

  // Enable drops one clk after the frame ends
  cipo_en_release: assert property (
    @(posedge clk) disable iff (!arst_n)
    $fell(byte_bus.frame_active) |=> !cipo_en
  );

endmodule

`default_nettype wire

//--- rtl/spi_word_framer.sv
`default_nettype none

// Packs eight bytes into one 64-bit word, little-endian
// Byte 0 of a frame ends up in bits 7:0
module spi_word_framer (
  input wire clk,
  input wire arst_n,
  spi_byte_if.framer byte_bus,
  output spi_target_pkg::spi_frame_u rx_word,
  output logic word_strobe,
  input wire spi_target_pkg::spi_frame_u tx_word
);

  // Position within the frame, 0 to 7
  // One extra bit so an overrun would be visible
  logic [3:0] byte_index;
  // Set on the byte that completes a frame
  logic last_byte;

  assign last_byte = (byte_index == 4'd7);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_index <= 4'd0;
      word_strobe <= 1'b0;
    end else begin
      // One clk after the strobe of byte 7
      word_strobe <= byte_bus.rx_strobe && last_byte;
      if (!byte_bus.frame_active) begin
        // CS released, drop any partial frame
        byte_index <= 4'd0;
      end else if (byte_bus.rx_strobe) begin
        if (last_byte) begin
          byte_index <= 4'd0;
        end else begin
          byte_index <= byte_index + 4'd1;
        end
      end
    end
  end

  // New bytes enter at the top and move down
  // After eight bytes the first one sits at 7:0
  always_ff @(posedge clk) begin
    if (byte_bus.rx_strobe) begin
      rx_word.raw <= {byte_bus.rx_byte, rx_word.raw[63:8]};
    end
  end

  // Reply byte for the current position, same order as receive
  // Index 0 while idle, so byte 0 is ready before CS goes low
  assign byte_bus.tx_byte = tx_word.raw[{byte_index[2:0], 3'b000} +: 8];

  // Counter wraps at 7 and never reaches 8
  byte_index_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    byte_index <= 4'd7
  );

endmodule

`default_nettype wire

//--- rtl/spi_reg_file.sv
`default_nettype none

`include "spi_target_consts.svh"

// Command decode and register storage
// Reply to a word is loaded at once and shifted out in the next frame
module spi_reg_file (
  input wire clk,
  input wire arst_n,
  input wire spi_target_pkg::spi_frame_u rx_word,
  input wire word_strobe,
  output spi_target_pkg::spi_frame_u tx_word,
  output logic [31:0] ctrl
);

  // Read/write registers 1 up, register 0 is the fixed ID
  logic [`SPI_REG_COUNT-1:1][31:0] regs;

  spi_target_pkg::spi_cmd_t cmd;
  spi_target_pkg::spi_frame_u reply;
  // Address points at a register that exists
  logic addr_valid;
  // Address is writable, ID excluded
  logic addr_writable;
  // Low address bits used as the register index
  logic [$clog2(`SPI_REG_COUNT)-1:0] reg_index;
  logic [31:0] read_data;
  logic do_write;

  assign cmd = rx_word.cmd;
  assign reg_index = cmd.addr[$clog2(`SPI_REG_COUNT)-1:0];
  assign addr_valid = (cmd.addr < `SPI_REG_COUNT);
  assign addr_writable = addr_valid && (cmd.addr != 8'd0);
  assign do_write = word_strobe && (cmd.op == `SPI_OP_WRITE) && addr_writable;

  // Register read mux
  always_comb begin
    read_data = 32'h0;
    if (cmd.addr == 8'd0) begin
      read_data = `SPI_REG_ID_VALUE;
    end else if (addr_valid) begin
      read_data = regs[reg_index];
    end
  end

  // Reply word for the received command
  always_comb begin
    reply.raw = 64'h0;
    case (cmd.op)
      // Echo, even when the write was dropped
      `SPI_OP_WRITE: reply = rx_word;
      `SPI_OP_READ: begin
        reply.cmd.op = cmd.op;
        reply.cmd.addr = cmd.addr;
        reply.cmd.data = read_data;
      end
      // No-op or unknown, all zero
      default: reply.raw = 64'h0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '0;
      ctrl <= 32'h0;
      tx_word <= '0;
    end else if (word_strobe) begin
      tx_word <= reply;
      if (do_write) begin
        regs[reg_index] <= cmd.data;
        // ctrl pin mirrors register 1
        if (reg_index == 1) begin
          ctrl <= cmd.data;
        end
      end
    end
  end

  // Separate ctrl flop must track its register
  ctrl_tracks_reg1: assert property (
    @(posedge clk) disable iff (!arst_n)
    ctrl == regs[1]
  );

  // Storage and reply only move on a word strobe
  state_change_on_strobe: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$stable({regs, tx_word, ctrl}) |-> $past(word_strobe)
  );

endmodule

`default_nettype wire

//--- rtl/spi_reg_target.sv
`default_nettype none

// SPI register target
// Byte engine -> word framer -> register file
module spi_reg_target (
  input wire clk,
  input wire arst_n,
  input wire sck,
  input wire cs_n,
  input wire copi,
  output wire cipo,
  output wire cipo_en,
  output wire [31:0] ctrl
);

  // Link between byte engine and framer
  spi_byte_if byte_bus ();

  // Word path between framer and register file
  spi_target_pkg::spi_frame_u rx_word;
  spi_target_pkg::spi_frame_u tx_word;
  wire word_strobe;

  spi_byte_engine i_spi_byte_engine (
    .clk (clk),
    .arst_n (arst_n),
    .sck (sck),
    .cs_n (cs_n),
    .copi (copi),
    .cipo (cipo),
    .cipo_en (cipo_en),
    .byte_bus (byte_bus.engine)
  );

  spi_word_framer i_spi_word_framer (
    .clk (clk),
    .arst_n (arst_n),
    .byte_bus (byte_bus.framer),
    .rx_word (rx_word),
    .word_strobe (word_strobe),
    .tx_word (tx_word)
  );

  spi_reg_file i_spi_reg_file (
    .clk (clk),
    .arst_n (arst_n),
    .rx_word (rx_word),
    .word_strobe (word_strobe),
    .tx_word (tx_word),
    .ctrl (ctrl)
  );

endmodule

`default_nettype wire

//--- bench/spi_host_tasks.svh
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// SPI host side in Mode 0
// Drives sck, cs_n and copi and samples cipo of the including module

// Clk cycles per SCK half period, SCK runs at clk/8
localparam int SCK_HALF_CYCLES = 4;
// Clk cycles from CS low to the first SCK edge
localparam int CS_SETUP_CYCLES = 2;
// CS hold after the last falling SCK
localparam int CS_HOLD_CYCLES = 2;
// Idle time with CS high between frames
localparam int CS_GAP_CYCLES = 6;

// Step n rising clk edges, then move 1 ns past the edge
// All drives happen at that point, clear of the DUT sampling edge
task automatic wait_clocks(input int n);
  repeat (n) @(posedge clk);
  #1;
endtask

// One byte, MSB first
// COPI is set while SCK is low, CIPO sampled right before the rising edge
task automatic spi_send_byte(input logic [7:0] tx, output logic [7:0] rx);
  for (int i = 7; i >= 0; i--) begin
    copi = tx[i];
    wait_clocks(SCK_HALF_CYCLES);
    rx[i] = cipo;
    sck = 1'b1;
    wait_clocks(SCK_HALF_CYCLES);
    // COPI changes only after this falling edge
    sck = 1'b0;
  end
endtask

// Send the first num_bytes bytes of a word under one CS assertion
// Byte 0 is bits 7:0, received bytes land in the same order
task automatic spi_transfer(input logic [63:0] tx_bits, input int num_bytes,
                            output logic [63:0] rx_bits);
  logic [7:0] rx_byte;
  rx_bits = '0;
  cs_n = 1'b0;
  wait_clocks(CS_SETUP_CYCLES);
  for (int b = 0; b < num_bytes; b++) begin
    spi_send_byte(tx_bits[8*b +: 8], rx_byte);
    rx_bits[8*b +: 8] = rx_byte;
  end
  wait_clocks(CS_HOLD_CYCLES);
  cs_n = 1'b1;
  copi = 1'b0;
  // Lets the target see CS high and clear its byte count
  wait_clocks(CS_GAP_CYCLES);
endtask

// Full eight-byte frame
task automatic spi_frame(input logic [63:0] tx_bits, output logic [63:0] rx_bits);
  spi_transfer(tx_bits, 8, rx_bits);
endtask

`endif

//--- bench/spi_reg_tb.sv
`default_nettype none

`include "spi_target_consts.svh"

module spi_reg_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF_NS = 5;
  localparam int RESET_CYCLES = 16;
  // Full frames sent over all tests, the aborted one counted as full
  localparam int NUM_FRAMES = 28;
  localparam logic [7:0] OP_NOP = 8'h00;

  logic clk = 1'b0;
  logic arst_n;
  logic sck;
  logic cs_n;
  logic copi;
  wire cipo;
  wire cipo_en;
  wire [31:0] ctrl;

  int error_count = 0;
  int check_count = 0;
  logic [31:0] lcg_state = 32'h5e5e07bc;
  // Reply the target should shift out during the next frame
  logic [63:0] pending_reply = '0;
  // Last value written to each read/write register
  logic [31:0] wr_data [1:7];

  `include "spi_host_tasks.svh"

  localparam int FRAME_CYCLES = CS_SETUP_CYCLES + 64 * 2 * SCK_HALF_CYCLES
                                + CS_HOLD_CYCLES + CS_GAP_CYCLES;
  // Twice the nominal run length
  localparam int TIMEOUT_NS = 2 * (NUM_FRAMES * FRAME_CYCLES + RESET_CYCLES + 8
                                   + 2 * CS_GAP_CYCLES) * 2 * CLK_HALF_NS;

  spi_reg_target i_spi_reg_target (
    .clk (clk),
    .arst_n (arst_n),
    .sck (sck),
    .cs_n (cs_n),
    .copi (copi),
    .cipo (cipo),
    .cipo_en (cipo_en),
    .ctrl (ctrl)
  );

  always #CLK_HALF_NS clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Command word as laid out on the wire, op in the first byte
  function automatic logic [63:0] make_word(input logic [7:0] op, input logic [7:0] addr,
                                            input logic [31:0] data);
    return {data, 16'h0000, addr, op};
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  // Send a frame and check the reply to the one before it
  // next_reply is what this frame should produce one frame later
  task automatic run_frame(input logic [63:0] word, input logic [63:0] next_reply,
                           input string what);
    logic [63:0] got;
    spi_frame(word, got);
    check_value($sformatf("cipo word during %s", what), got, pending_reply);
    pending_reply = next_reply;
  endtask

  task automatic verify_reset_state();
    check_value("ctrl", {32'h0, ctrl}, 64'h0);
    check_value("cipo_en", {63'h0, cipo_en}, 64'h0);
    wait_clocks(4);
    // Still idle with CS high
    check_value("cipo_en", {63'h0, cipo_en}, 64'h0);
    // CS alone, no SCK, turns the output on and off again
    cs_n = 1'b0;
    wait_clocks(CS_GAP_CYCLES);
    check_value("cipo_en", {63'h0, cipo_en}, 64'h1);
    cs_n = 1'b1;
    wait_clocks(CS_GAP_CYCLES);
    check_value("cipo_en", {63'h0, cipo_en}, 64'h0);
  endtask

  task automatic read_id_register();
    run_frame(make_word(`SPI_OP_READ, 8'h00, 32'h0),
              make_word(`SPI_OP_READ, 8'h00, `SPI_REG_ID_VALUE), "id read");
    run_frame(make_word(OP_NOP, 8'h00, 32'h0), 64'h0, "nop after id read");
    // All-zero reply of the no-op comes back here
    run_frame(make_word(OP_NOP, 8'h00, 32'h0), 64'h0, "second nop");
  endtask

  task automatic write_then_read_back();
    logic [63:0] word;
    for (int a = 1; a < 8; a++) begin
      wr_data[a] = lcg_next();
      word = make_word(`SPI_OP_WRITE, a[7:0], wr_data[a]);
      // Write is echoed as received
      run_frame(word, word, $sformatf("write %0d", a));
    end
    check_value("ctrl", {32'h0, ctrl}, {32'h0, wr_data[1]});
    for (int a = 1; a < 8; a++) begin
      run_frame(make_word(`SPI_OP_READ, a[7:0], 32'h0),
                make_word(`SPI_OP_READ, a[7:0], wr_data[a]), $sformatf("read %0d", a));
    end
    check_value("ctrl", {32'h0, ctrl}, {32'h0, wr_data[1]});
  endtask

  task automatic probe_protected_addresses();
    logic [63:0] word;
    word = make_word(`SPI_OP_WRITE, 8'h00, lcg_next());
    run_frame(word, word, "write 0");
    // Low bits of address 9 match register 1
    word = make_word(`SPI_OP_WRITE, 8'h09, lcg_next());
    run_frame(word, word, "write 9");
    check_value("ctrl", {32'h0, ctrl}, {32'h0, wr_data[1]});
    run_frame(make_word(`SPI_OP_READ, 8'h09, 32'h0),
              make_word(`SPI_OP_READ, 8'h09, 32'h0), "read 9");
    run_frame(make_word(`SPI_OP_READ, 8'h00, 32'h0),
              make_word(`SPI_OP_READ, 8'h00, `SPI_REG_ID_VALUE), "read 0");
    run_frame(make_word(`SPI_OP_READ, 8'h01, 32'h0),
              make_word(`SPI_OP_READ, 8'h01, wr_data[1]), "read 1");
  endtask

  task automatic abort_partial_write();
    logic [63:0] word;
    logic [63:0] partial;
    logic [31:0] new_data;
    new_data = lcg_next();
    word = make_word(`SPI_OP_WRITE, 8'h02, new_data);
    // Op, addr and one rsvd byte, then CS goes high
    spi_transfer(word, 3, partial);
    // First bytes of the pending reply went out, the reply itself stays
    check_value("cipo bytes during aborted frame", {40'h0, partial[23:0]},
                {40'h0, pending_reply[23:0]});
    run_frame(make_word(`SPI_OP_READ, 8'h02, 32'h0),
              make_word(`SPI_OP_READ, 8'h02, wr_data[2]), "read 2 after abort");
    run_frame(word, word, "write 2");
    wr_data[2] = new_data;
    run_frame(make_word(`SPI_OP_READ, 8'h02, 32'h0),
              make_word(`SPI_OP_READ, 8'h02, new_data), "read 2 after write");
    run_frame(make_word(OP_NOP, 8'h00, 32'h0), 64'h0, "nop after read 2");
  endtask

  initial begin
    arst_n = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    wait_clocks(4);
    verify_reset_state();
    read_id_register();
    write_then_read_back();
    probe_protected_addresses();
    abort_partial_write();
    // Picks up the reply of the last frame
    run_frame(make_word(OP_NOP, 8'h00, 32'h0), 64'h0, "final nop");
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #TIMEOUT_NS;
    $display("Timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
+incdir+bench
rtl/spi_target_pkg.sv
rtl/spi_byte_if.sv
rtl/spi_byte_engine.sv
rtl/spi_word_framer.sv
rtl/spi_reg_file.sv
rtl/spi_reg_target.sv
bench/spi_reg_tb.sv

//--- Makefile
SIM_TOOL := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP := spi_reg_tb
FILE_LIST := flist.f
BUILD_DIR := obj_dir
LOG_FILE := sim.log
FAIL_MSG := Testbench failed

.PHONY: sim clean

sim:
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG_FILE) 2>&1; status=$$?; \
	cat $(LOG_FILE); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG_FILE); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
